// ==== hdl/dcache_pkg.sv ====
// Data cache word and address types, block geometry and controller states
package dcache_pkg;

    // Datapath and memory bus widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Two words per block
    localparam int BLOCK_OFF_W  = 3;
    localparam int WORD_SEL_BIT = 2;   // Word inside a block

    typedef enum logic [3:0] {
        IDLE,          // Hits answered here
        CHECK,         // Victim dirty test
        WB1,
        WB2,
        FILL1,
        FILL2,
        FLUSH_CHECK,   // One frame per cycle
        FLUSH_WB1,
        FLUSH_WB2,
        DONE
    } ctrl_state_t;

endpackage

// ==== hdl/dcache_array_if.sv ====
// Controller to storage interface with ctrl and store modports
`timescale 1ns/100ps

interface dcache_array_if #(
    parameter int INDEX_W = 3
);
    // Driven by the controller
    logic               access_en;     // Datapath lookups allowed
    logic               fill_we;
    logic               fill_last;     // Completes the frame
    logic               word_sel;
    logic               flush_mode;
    logic [INDEX_W:0]   flush_frame;   // Way in the top bit
    logic               wb_clear;

    // Driven by the storage
    logic               hit;
    logic               sel_dirty;
    dcache_pkg::addr_t  sel_base_addr;
    dcache_pkg::word_t  sel_word;

    modport ctrl (
        output access_en,
        output fill_we,
        output fill_last,
        output word_sel,
        output flush_mode,
        output flush_frame,
        output wb_clear,
        input  hit,
        input  sel_dirty,
        input  sel_base_addr,
        input  sel_word
    );

    modport store (
        input  access_en,
        input  fill_we,
        input  fill_last,
        input  word_sel,
        input  flush_mode,
        input  flush_frame,
        input  wb_clear,
        output hit,
        output sel_dirty,
        output sel_base_addr,
        output sel_word
    );

endinterface

// ==== hdl/dcache_store.sv ====
// Two-way set storage with tag compare, hit data path, fills and victim or flush frame select
`timescale 1ns/100ps

module dcache_store #(
    parameter int INDEX_W = 3
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                dmem_ren_i,
    input  logic                dmem_wen_i,
    input  dcache_pkg::addr_t   dmem_addr_i,
    input  dcache_pkg::word_t   dmem_store_i,
    input  dcache_pkg::word_t   mem_load_i,
    output dcache_pkg::word_t   dmem_load_o,
    output logic                dhit_o,
    dcache_array_if.store       arr
);
    localparam int ADDR_W = $bits(dcache_pkg::addr_t);
    localparam int SETS   = 1 << INDEX_W;
    localparam int TAG_W  = ADDR_W - INDEX_W - dcache_pkg::BLOCK_OFF_W;

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // Frame state, way in the outer dimension
    logic [1:0][SETS-1:0] valid;
    logic [1:0][SETS-1:0] dirty;
    logic [SETS-1:0]      mru;                // Way used last in each set
    tag_t                 tags [2][SETS];
    dcache_pkg::word_t    data [2][SETS][2];

    tag_t       req_tag;
    index_t     req_idx;
    logic       req_word;
    logic       access;
    logic [1:0] way_hit;
    logic       hit;
    logic       hit_way;
    logic       wr_hit;
    index_t     sel_idx;
    logic       sel_way;

    assign req_tag  = dmem_addr_i[ADDR_W-1 -: TAG_W];
    assign req_idx  = dmem_addr_i[dcache_pkg::BLOCK_OFF_W +: INDEX_W];
    assign req_word = dmem_addr_i[dcache_pkg::WORD_SEL_BIT];
    assign access   = dmem_ren_i | dmem_wen_i;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid[w][req_idx] && (tags[w][req_idx] == req_tag);
        end
    end

    assign hit     = access & (|way_hit);
    assign hit_way = ~way_hit[0];                 // Left way wins
    assign arr.hit = hit;

    assign dhit_o      = arr.access_en & hit;
    assign dmem_load_o = data[hit_way][req_idx][req_word];
    assign wr_hit      = dhit_o & dmem_wen_i;

    // LRU victim for misses, counter frame while flushing
    assign sel_idx = arr.flush_mode ? arr.flush_frame[INDEX_W-1:0] : req_idx;
    assign sel_way = arr.flush_mode ? arr.flush_frame[INDEX_W] : ~mru[req_idx];

    assign arr.sel_dirty     = valid[sel_way][sel_idx] & dirty[sel_way][sel_idx];
    assign arr.sel_base_addr = {tags[sel_way][sel_idx], sel_idx,
                                {dcache_pkg::BLOCK_OFF_W{1'b0}}};
    assign arr.sel_word      = data[sel_way][sel_idx][arr.word_sel];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
            mru   <= '0;
        end else begin
            if (dhit_o) begin
                mru[req_idx] <= hit_way;
            end
            if (wr_hit) begin
                dirty[hit_way][req_idx] <= 1'b1;
            end
            if (arr.fill_we && arr.fill_last) begin
                valid[sel_way][sel_idx] <= 1'b1;
                dirty[sel_way][sel_idx] <= 1'b0;   // Fresh copy of memory
            end
            if (arr.wb_clear) begin
                dirty[sel_way][sel_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_hit) begin
            data[hit_way][req_idx][req_word] <= dmem_store_i;
        end
        if (arr.fill_we) begin
            data[sel_way][sel_idx][arr.word_sel] <= mem_load_i;
        end
        if (arr.fill_we && arr.fill_last) begin
            tags[sel_way][sel_idx] <= req_tag;
        end
    end

endmodule

// ==== hdl/dcache_ctrl.sv ====
// Miss, writeback, fill and flush FSM with flush counter and memory bus outputs
`timescale 1ns/100ps

module dcache_ctrl #(
    parameter int INDEX_W = 3
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                dmem_ren_i,
    input  logic                dmem_wen_i,
    input  logic                halt_i,
    input  dcache_pkg::addr_t   dmem_addr_i,
    input  logic                mem_wait_i,
    output logic                mem_ren_o,
    output logic                mem_wen_o,
    output dcache_pkg::addr_t   mem_addr_o,
    output dcache_pkg::word_t   mem_store_o,
    output logic                flushed_o,
    dcache_array_if.ctrl        arr
);
    localparam int ADDR_W = $bits(dcache_pkg::addr_t);
    localparam int TAG_W  = ADDR_W - INDEX_W - dcache_pkg::BLOCK_OFF_W;
    localparam int FRAMES = 2 << INDEX_W;

    typedef logic [INDEX_W+1:0] flush_cnt_t;

    dcache_pkg::ctrl_state_t state, nxt_state;
    flush_cnt_t              flush_cnt, nxt_flush_cnt;
    dcache_pkg::addr_t       fill_addr;
    dcache_pkg::addr_t       wb_addr;
    logic                    flush_end;

    assign flush_end       = (flush_cnt == flush_cnt_t'(FRAMES));
    assign arr.flush_frame = flush_cnt[INDEX_W:0];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= dcache_pkg::IDLE;
            flush_cnt <= '0;
        end else begin
            state     <= nxt_state;
            flush_cnt <= nxt_flush_cnt;
        end
    end

    always_comb begin
        nxt_state     = state;
        nxt_flush_cnt = flush_cnt;
        case (state)
            dcache_pkg::IDLE: begin
                if (halt_i) begin
                    nxt_state = dcache_pkg::FLUSH_CHECK;
                end else if ((dmem_ren_i || dmem_wen_i) && !arr.hit) begin
                    nxt_state = dcache_pkg::CHECK;
                end
            end
            dcache_pkg::CHECK: begin
                if (arr.sel_dirty) begin
                    nxt_state = dcache_pkg::WB1;
                end else begin
                    nxt_state = dcache_pkg::FILL1;
                end
            end
            dcache_pkg::WB1: begin
                if (!mem_wait_i) begin
                    nxt_state = dcache_pkg::WB2;
                end
            end
            dcache_pkg::WB2: begin
                if (!mem_wait_i) begin
                    nxt_state = dcache_pkg::FILL1;
                end
            end
            dcache_pkg::FILL1: begin
                if (!mem_wait_i) begin
                    nxt_state = dcache_pkg::FILL2;
                end
            end
            dcache_pkg::FILL2: begin
                if (!mem_wait_i) begin
                    nxt_state = dcache_pkg::IDLE;   // Request hits next
                end
            end
            dcache_pkg::FLUSH_CHECK: begin
                if (flush_end) begin
                    nxt_state = dcache_pkg::DONE;
                end else if (arr.sel_dirty) begin
                    nxt_state = dcache_pkg::FLUSH_WB1;   // Same frame rechecked after
                end else begin
                    nxt_flush_cnt = flush_cnt + 1'b1;
                end
            end
            dcache_pkg::FLUSH_WB1: begin
                if (!mem_wait_i) begin
                    nxt_state = dcache_pkg::FLUSH_WB2;
                end
            end
            dcache_pkg::FLUSH_WB2: begin
                if (!mem_wait_i) begin
                    nxt_state = dcache_pkg::FLUSH_CHECK;
                end
            end
            dcache_pkg::DONE: begin
                nxt_state = dcache_pkg::DONE;   // Held until reset
            end
            default: begin
                nxt_state = dcache_pkg::IDLE;
            end
        endcase
    end

    always_comb begin
        arr.access_en  = 1'b0;
        arr.fill_we    = 1'b0;
        arr.fill_last  = 1'b0;
        arr.word_sel   = 1'b0;
        arr.flush_mode = 1'b0;
        arr.wb_clear   = 1'b0;
        mem_ren_o      = 1'b0;
        mem_wen_o      = 1'b0;
        flushed_o      = 1'b0;
        case (state)
            dcache_pkg::IDLE: begin
                arr.access_en = 1'b1;
            end
            dcache_pkg::WB1: begin
                mem_wen_o = 1'b1;
            end
            dcache_pkg::WB2: begin
                mem_wen_o    = 1'b1;
                arr.word_sel = 1'b1;
                arr.wb_clear = ~mem_wait_i;
            end
            dcache_pkg::FILL1: begin
                mem_ren_o   = 1'b1;
                arr.fill_we = ~mem_wait_i;
            end
            dcache_pkg::FILL2: begin
                mem_ren_o     = 1'b1;
                arr.word_sel  = 1'b1;
                arr.fill_we   = ~mem_wait_i;
                arr.fill_last = ~mem_wait_i;
            end
            dcache_pkg::FLUSH_CHECK: begin
                arr.flush_mode = 1'b1;
            end
            dcache_pkg::FLUSH_WB1: begin
                arr.flush_mode = 1'b1;
                mem_wen_o      = 1'b1;
            end
            dcache_pkg::FLUSH_WB2: begin
                arr.flush_mode = 1'b1;
                mem_wen_o      = 1'b1;
                arr.word_sel   = 1'b1;
                arr.wb_clear   = ~mem_wait_i;
            end
            dcache_pkg::DONE: begin
                flushed_o = 1'b1;
            end
            default: begin
                arr.access_en = 1'b0;
            end
        endcase
    end

    // Block addresses with the word bit patched in
    always_comb begin
        fill_addr = {dmem_addr_i[ADDR_W-1 -: TAG_W],
                     dmem_addr_i[dcache_pkg::BLOCK_OFF_W +: INDEX_W],
                     {dcache_pkg::BLOCK_OFF_W{1'b0}}};
        wb_addr   = arr.sel_base_addr;
        fill_addr[dcache_pkg::WORD_SEL_BIT] = arr.word_sel;
        wb_addr[dcache_pkg::WORD_SEL_BIT]   = arr.word_sel;
    end

    assign mem_addr_o  = mem_wen_o ? wb_addr : fill_addr;
    assign mem_store_o = arr.sel_word;

endmodule

// ==== hdl/dcache_top.sv ====
// Data cache top level joining storage and controller
`timescale 1ns/100ps

module dcache_top #(
    parameter int INDEX_W = 3      // 8 sets
) (
    input  logic                CLK,
    input  logic                nRST,

    // Datapath side
    input  logic                dmem_ren_i,
    input  logic                dmem_wen_i,
    input  dcache_pkg::addr_t   dmem_addr_i,
    input  dcache_pkg::word_t   dmem_store_i,
    input  logic                halt_i,
    output dcache_pkg::word_t   dmem_load_o,
    output logic                dhit_o,
    output logic                flushed_o,

    // Memory side
    output logic                mem_ren_o,
    output logic                mem_wen_o,
    output dcache_pkg::addr_t   mem_addr_o,
    output dcache_pkg::word_t   mem_store_o,
    input  dcache_pkg::word_t   mem_load_i,
    input  logic                mem_wait_i
);

    dcache_array_if #(
        .INDEX_W (INDEX_W)
    ) arr ();

    dcache_store #(
        .INDEX_W (INDEX_W)
    ) i_store (
        .CLK          (CLK),
        .nRST         (nRST),
        .dmem_ren_i   (dmem_ren_i),
        .dmem_wen_i   (dmem_wen_i),
        .dmem_addr_i  (dmem_addr_i),
        .dmem_store_i (dmem_store_i),
        .mem_load_i   (mem_load_i),
        .dmem_load_o  (dmem_load_o),
        .dhit_o       (dhit_o),
        .arr          (arr.store)
    );

    dcache_ctrl #(
        .INDEX_W (INDEX_W)
    ) i_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .dmem_ren_i  (dmem_ren_i),
        .dmem_wen_i  (dmem_wen_i),
        .halt_i      (halt_i),
        .dmem_addr_i (dmem_addr_i),
        .mem_wait_i  (mem_wait_i),
        .mem_ren_o   (mem_ren_o),
        .mem_wen_o   (mem_wen_o),
        .mem_addr_o  (mem_addr_o),
        .mem_store_o (mem_store_o),
        .flushed_o   (flushed_o),
        .arr         (arr.ctrl)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
// Testbench clock and power-on reset generator
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 50,    // 100 ns clock
    parameter int RST_CYCLES  = 10
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (RST_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;                   // Released away from the active edge
    end

endmodule

// ==== bench/dcache_tb.sv ====
// Data cache testbench with memory model, shadow map, LFSR, compare tasks and directed tests
`timescale 1ns/100ps

module dcache_tb;

    localparam int          RST_CYCLES   = 10;
    localparam int          MEM_WORDS    = 1024;
    localparam logic [15:0] SEED         = 16'd42690;
    localparam int          N_DIRECTED   = 16;
    localparam int          N_RAND       = 120;
    localparam int          ACCESS_CYC   = 100;     // Worst case with waits
    localparam int          FLUSH_CYC    = 16 * 40;
    localparam int          WATCHDOG_CYC = RST_CYCLES + (N_DIRECTED + N_RAND) * ACCESS_CYC
                                           + FLUSH_CYC;

    logic              CLK;
    logic              nRST;
    logic              dmem_ren_i;
    logic              dmem_wen_i;
    dcache_pkg::addr_t dmem_addr_i;
    dcache_pkg::word_t dmem_store_i;
    logic              halt_i;
    dcache_pkg::word_t dmem_load_o;
    logic              dhit_o;
    logic              flushed_o;
    logic              mem_ren_o;
    logic              mem_wen_o;
    dcache_pkg::addr_t mem_addr_o;
    dcache_pkg::word_t mem_store_o;
    dcache_pkg::word_t mem_load_i;
    logic              mem_wait_i;

    dcache_pkg::word_t mem [MEM_WORDS];
    dcache_pkg::word_t shadow [dcache_pkg::addr_t];   // Words stored by the tests
    logic [15:0]       wait_lfsr = SEED;
    logic [15:0]       data_lfsr = SEED;
    int                checks = 0;
    int                errors = 0;

    tb_clock_gen #(
        .RST_CYCLES (RST_CYCLES)
    ) i_clock_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    dcache_top #(
        .INDEX_W (3)
    ) i_dcache_top (
        .CLK          (CLK),
        .nRST         (nRST),
        .dmem_ren_i   (dmem_ren_i),
        .dmem_wen_i   (dmem_wen_i),
        .dmem_addr_i  (dmem_addr_i),
        .dmem_store_i (dmem_store_i),
        .halt_i       (halt_i),
        .dmem_load_o  (dmem_load_o),
        .dhit_o       (dhit_o),
        .flushed_o    (flushed_o),
        .mem_ren_o    (mem_ren_o),
        .mem_wen_o    (mem_wen_o),
        .mem_addr_o   (mem_addr_o),
        .mem_store_o  (mem_store_o),
        .mem_load_i   (mem_load_i),
        .mem_wait_i   (mem_wait_i)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic dcache_pkg::word_t rand_bits(input int n);
        dcache_pkg::word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            data_lfsr = lfsr_next(data_lfsr);
            v = {v[30:0], data_lfsr[0]};
        end
        return v;
    endfunction

    // Initial memory contents
    function automatic dcache_pkg::word_t init_word(input dcache_pkg::addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'h0BAD_F00D;
    endfunction

    function automatic dcache_pkg::word_t expected_word(input dcache_pkg::addr_t a);
        dcache_pkg::word_t v;
        if (shadow.exists(a)) begin
            v = shadow[a];
        end else begin
            v = init_word(a);
        end
        return v;
    endfunction

    // Memory model takes one transfer per cycle with mem_wait_i low
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i[9:0]] = init_word(dcache_pkg::addr_t'(i << 2));
        end
        forever begin
            @(posedge CLK);
            if (mem_wen_o && !mem_wait_i) begin
                mem[mem_addr_o[11:2]] <= mem_store_o;
            end
        end
    end

    // Bus data valid only for an accepted read
    assign mem_load_i = (mem_ren_o && !mem_wait_i) ? mem[mem_addr_o[11:2]]
                                                   : ~mem[mem_addr_o[11:2]];

    initial begin
        mem_wait_i = 1'b0;
        forever begin
            @(negedge CLK);
            wait_lfsr  = lfsr_next(wait_lfsr);
            mem_wait_i = wait_lfsr[0];
        end
    end

    task automatic check_word(input string name, input dcache_pkg::word_t exp,
                              input dcache_pkg::word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Request held from a falling edge until one edge after dhit_o
    task automatic dmem_access(input string name, input logic wr, input dcache_pkg::addr_t addr,
                               input dcache_pkg::word_t wdata, output int cycles);
        dcache_pkg::word_t exp;
        exp          = expected_word(addr);
        dmem_ren_i   = !wr;
        dmem_wen_i   = wr;
        dmem_addr_i  = addr;
        dmem_store_i = wdata;
        cycles       = 0;
        do begin
            @(negedge CLK);
            cycles++;
        end while (!dhit_o);
        if (!wr) begin
            check_word(name, exp, dmem_load_o);
        end
        @(negedge CLK);                // Edge that takes the hit
        dmem_ren_i = 1'b0;
        dmem_wen_i = 1'b0;
        if (wr) begin
            shadow[addr] = wdata;
        end
    endtask

    task automatic load_check(input string name, input dcache_pkg::addr_t addr,
                              output int cycles);
        dmem_access(name, 1'b0, addr, '0, cycles);
    endtask

    task automatic store_word(input string name, input dcache_pkg::addr_t addr,
                              input dcache_pkg::word_t data);
        int cycles;
        dmem_access(name, 1'b1, addr, data, cycles);
    endtask

    task automatic read_miss_test;
        int cycles;
        load_check("read_miss", 32'h108, cycles);
        load_check("read_miss second word", 32'h10C, cycles);
        check_bit("read_miss second word hit", 1'b1, cycles == 1);
    endtask

    task automatic write_hit_test;
        int cycles;
        store_word("write_hit", 32'h10C, 32'hC0FF_EE01);
        load_check("write_hit", 32'h10C, cycles);
        check_word("write_hit memory", init_word(32'h10C), mem[10'h043]);
    endtask

    // A lands in way 1 and B in way 0 of set 2 so that C evicts A
    task automatic eviction_test;
        int cycles;
        store_word("eviction", 32'h210, 32'hA0A0_1234);
        load_check("eviction B", 32'h250, cycles);
        load_check("eviction C", 32'h290, cycles);
        check_word("eviction memory", 32'hA0A0_1234, mem[10'h084]);
        load_check("eviction reload", 32'h210, cycles);
    endtask

    task automatic back_pressure_test;
        dcache_pkg::word_t wr;
        dcache_pkg::word_t tag;
        dcache_pkg::word_t idx;
        dcache_pkg::word_t w;
        dcache_pkg::word_t data;
        dcache_pkg::addr_t addr;
        int                cycles;
        for (int n = 0; n < N_RAND; n++) begin
            wr   = rand_bits(1);
            tag  = rand_bits(2);
            idx  = rand_bits(2);
            w    = rand_bits(1);
            data = rand_bits(32);
            addr = 32'h400 + (tag << 6) + ((idx + 32'd4) << 3) + (w << 2);   // Sets 4 to 7
            if (wr[0]) begin
                store_word("back_pressure", addr, data);
            end else begin
                load_check("back_pressure", addr, cycles);
            end
        end
    endtask

    task automatic flush_test;
        for (int s = 0; s < 4; s++) begin
            store_word("flush store", 32'h600 + (s << 3), 32'hF100_0000 + s);
        end
        check_bit("flush before halt", 1'b0, flushed_o);
        halt_i = 1'b1;
        while (!flushed_o) begin
            @(negedge CLK);
        end
        repeat (2) @(negedge CLK);
        check_bit("flush", 1'b1, flushed_o);
        foreach (shadow[a]) begin
            check_word("flush memory", shadow[a], mem[a[11:2]]);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge CLK);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        dmem_ren_i   = 1'b0;
        dmem_wen_i   = 1'b0;
        dmem_addr_i  = '0;
        dmem_store_i = '0;
        halt_i       = 1'b0;
        @(posedge nRST);
        @(negedge CLK);
        check_bit("reset dhit", 1'b0, dhit_o);
        check_bit("reset flushed", 1'b0, flushed_o);
        check_bit("reset mem_ren", 1'b0, mem_ren_o);
        check_bit("reset mem_wen", 1'b0, mem_wen_o);
        read_miss_test();
        write_hit_test();
        eviction_test();
        back_pressure_test();
        flush_test();                  // Leaves the cache halted
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/dcache_pkg.sv
hdl/dcache_array_if.sv
hdl/dcache_store.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
bench/tb_clock_gen.sv
bench/dcache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --timescale 1ns/100ps \
        -f sources.f --top-module dcache_tb -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "Simulation completed successfully" sim.log \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
